// File: tb/decode_tests.txt
// instr_valid instr pc wb_valid wb_rd wb_data | expected: stall out_valid control imm
// rs1_data rs2_data rd (out fields are those of the cycle after the vector, all hex)
1 002081b3 00000100 0 00 00000000 0 1 0004ff10 00000000 00000000 00000000 03
0 00700293 00000104 1 03 12345678 0 0 00000000 00000000 00000000 00000000 00
1 00328333 00000108 1 01 000000a1 0 1 0004ff10 00000000 00000000 12345678 06
1 abcde437 0000010c 1 06 00000066 0 1 040cff10 abcde000 00000000 00000000 08
1 00001497 00000110 1 08 00000088 0 1 040eff10 00001000 00000000 00000000 09
1 ff9ff56f 00000114 0 00 00000000 0 1 050e8f30 fffffff8 00000000 00000000 0a
1 010085e7 00000118 0 00 00000000 0 1 010c8f30 00000010 000000a1 00000000 0b
1 fe3098e3 0000011c 0 00 00000000 0 1 030e1f00 fffffff0 000000a1 12345678 11
1 4041d613 00000120 1 02 00000b02 0 1 01dcff10 00000404 12345678 00000000 0c
1 401186b3 00000124 0 00 00000000 0 1 0084ff10 00000000 12345678 000000a1 0d
1 02208733 00000128 0 00 00000000 0 1 0004ff70 00000000 000000a1 00000b02 0e
1 ffc12783 0000012c 0 00 00000000 0 1 010cf250 fffffffc 00000b02 00000000 0f
1 0030a423 00000130 0 00 00000000 0 1 020cfac0 00000008 000000a1 12345678 08
1 30009873 00000134 0 00 00000000 0 1 010cff98 00000300 000000a1 00000000 10
1 0001800b 00000138 0 00 00000000 0 1 000cff04 00000000 12345678 00000000 00
1 0000188b 0000013c 0 00 00000000 0 1 000cffb2 00000000 00000000 00000000 11
1 0000290b 00000140 0 00 00000000 0 1 000cff01 00000000 00000000 00000000 12
1 000009ff 00000144 0 00 00000000 0 1 010cff01 00000000 00000000 00000000 13
1 00508013 00000148 0 00 00000000 0 1 010cff00 00000005 000000a1 00000000 00
1 00520a33 0000014c 1 04 deadbeef 0 1 0004ff10 00000000 deadbeef 00000000 14
1 00400ab3 00000150 1 00 ffffffff 0 1 0004ff10 00000000 00000000 deadbeef 15
1 00108b13 00000154 0 00 00000000 0 1 010cff10 00000001 000000a1 000000a1 16
1 001b0bb3 00000158 0 00 00000000 1 0 00000000 00000000 00000000 00000000 00
1 001b0bb3 00000158 0 00 00000000 1 0 00000000 00000000 00000000 00000000 00
1 001b0bb3 00000158 1 16 000000a2 0 1 0004ff10 00000000 000000a2 000000a1 17
1 000b0c33 0000015c 0 00 00000000 0 1 0004ff10 00000000 000000a2 00000000 18
0 000b8cb3 00000160 0 00 00000000 0 0 00000000 00000000 00000000 00000000 00
1 41708d33 00000164 1 05 00000055 1 0 00000000 00000000 00000000 00000000 00
1 41708d33 00000164 1 17 23232323 0 1 0084ff10 00000000 000000a1 23232323 1a
0 00000000 00000168 0 00 00000000 0 0 00000000 00000000 00000000 00000000 00

// File: filelist.f
logic/rv32_types.sv
logic/rv32_decoder.sv
logic/rv32_imm_gen.sv
logic/rv32_reg_file.sv
logic/rv32_scoreboard.sv
logic/rv32_decode_stage.sv
tb/tb_decode_stage.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int WORDS_PER_VECTOR = 13;
    localparam int MAX_VECTORS = 64;

    // Column order of one vector in the test file
    localparam int COL_INSTR_VALID = 0;
    localparam int COL_INSTR = 1;
    localparam int COL_PC = 2;
    localparam int COL_WB_VALID = 3;
    localparam int COL_WB_RD = 4;
    localparam int COL_WB_DATA = 5;
    localparam int COL_EXP_STALL = 6;
    localparam int COL_EXP_VALID = 7;
    localparam int COL_EXP_CONTROL = 8;
    localparam int COL_EXP_IMM = 9;
    localparam int COL_EXP_RS1_DATA = 10;
    localparam int COL_EXP_RS2_DATA = 11;
    localparam int COL_EXP_RD = 12;

    logic                    clk;
    logic                    arst_n;
    logic                    instr_valid;
    rv32_types::rv_instr_t   instr;
    logic [31:0]             pc;
    rv32_types::wb_port_t    wb;
    rv32_types::decode_out_t decode_out;
    logic                    stall;

    logic [31:0] vectors [MAX_VECTORS * WORDS_PER_VECTOR];
    int          num_vectors;
    bit          vectors_loaded;

    rv32_decode_stage #(
        .ENABLE_GRNG(1'b1)
    ) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .pc         (pc),
        .wb         (wb),
        .out        (decode_out),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] vector_word(input int vec, input int col);
        return vectors[vec * WORDS_PER_VECTOR + col];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic load_vectors();
        for (int a = 0; a < MAX_VECTORS * WORDS_PER_VECTOR; a++) begin
            // Unused slots never hold 0 or 1 in the valid column
            vectors[a] = 32'hf000_0000 | 32'(a);
        end
        $readmemh("tb/decode_tests.txt", vectors);
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS &&
               vector_word(num_vectors, COL_INSTR_VALID) < 32'd2) begin
            num_vectors++;
        end
    endtask

    task automatic apply_vector(input int k);
        logic [31:0] rd_word;
        rd_word = vector_word(k, COL_WB_RD);
        instr_valid = vector_word(k, COL_INSTR_VALID) != 32'd0;
        instr = vector_word(k, COL_INSTR);
        pc = vector_word(k, COL_PC);
        wb.valid = vector_word(k, COL_WB_VALID) != 32'd0;
        wb.rd = rd_word[4:0];
        wb.data = vector_word(k, COL_WB_DATA);
    endtask

    // Fields other than valid only matter when an instruction issued
    task automatic check_outputs(input int k);
        logic [31:0] instr_word;
        instr_word = vector_word(k, COL_INSTR);
        compare_value("out.valid", {31'd0, decode_out.valid}, vector_word(k, COL_EXP_VALID));
        if (vector_word(k, COL_EXP_VALID) != 32'd0) begin
            compare_value("out.pc", decode_out.pc, vector_word(k, COL_PC));
            compare_value("out.control", {5'd0, decode_out.control},
                          vector_word(k, COL_EXP_CONTROL));
            compare_value("out.imm", decode_out.imm, vector_word(k, COL_EXP_IMM));
            compare_value("out.rs1_data", decode_out.rs1_data, vector_word(k, COL_EXP_RS1_DATA));
            compare_value("out.rs2_data", decode_out.rs2_data, vector_word(k, COL_EXP_RS2_DATA));
            // Source fields sit at the same bits in every format
            compare_value("out.rs1", {27'd0, decode_out.rs1}, {27'd0, instr_word[19:15]});
            compare_value("out.rs2", {27'd0, decode_out.rs2}, {27'd0, instr_word[24:20]});
            compare_value("out.rd", {27'd0, decode_out.rd}, vector_word(k, COL_EXP_RD));
        end
    endtask

    initial begin
        arst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        wb = '0;
        load_vectors();
        vectors_loaded = 1'b1;
        if (num_vectors == 0) begin
            $display("no test vectors could be read from tb/decode_tests.txt");
            $display("Test failed");
            $fatal(1, "empty test file");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            arst_n = 1'b1;
            compare_value("out.valid", {31'd0, decode_out.valid}, 32'd0);
            compare_value("stall", {31'd0, stall}, 32'd0);
            // Out from vector k is checked on the edge after it was driven
            for (int k = 0; k <= num_vectors; k++) begin
                @(posedge clk);
                #1;
                if (k > 0) begin
                    check_outputs(k - 1);
                end
                if (k < num_vectors) begin
                    apply_vector(k);
                    #1;
                    compare_value("stall", {31'd0, stall}, vector_word(k, COL_EXP_STALL));
                end
            end
            $display("Test completed successfully");
            $finish;
        end
    end

    // Watchdog scaled to the vector count
    initial begin
        int timeout_ns;
        wait (vectors_loaded);
        timeout_ns = (num_vectors + 20) * CLK_PERIOD;
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the run hung", timeout_ns);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

// File: logic/rv32_decode_stage.sv
`timescale 1ns/1ns

module rv32_decode_stage #(
    parameter bit ENABLE_GRNG = 1'b1
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  rv32_types::rv_instr_t   instr,
    input  logic [31:0]             pc,
    input  rv32_types::wb_port_t    wb,
    output rv32_types::decode_out_t out,
    output logic                    stall
);

    rv32_types::rv_control_t control;
    logic                    use_rs [rv32_types::CORE_RF_NUM_READ];
    logic [31:0]             imm;
    logic [31:0]             rs1_data;
    logic [31:0]             rs2_data;
    logic                    issue;

    rv32_decoder #(
        .ENABLE_GRNG(ENABLE_GRNG)
    ) decoder0 (
        .instr  (instr),
        .control(control),
        .use_rs (use_rs)
    );

    rv32_imm_gen imm_gen0 (
        .instr(instr),
        .t    (control.t),
        .imm  (imm)
    );

    rv32_reg_file reg_file0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1     (instr.r.rs1),
        .rs2     (instr.r.rs2),
        .wb      (wb),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    // Only issued instructions that write rd reserve it
    rv32_scoreboard scoreboard0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .use_rs     (use_rs),
        .rs1        (instr.r.rs1),
        .rs2        (instr.r.rs2),
        .instr_valid(instr_valid),
        .mark       (issue && control.register_wb),
        .mark_rd    (instr.r.rd),
        .wb         (wb),
        .stall      (stall)
    );

    assign issue = instr_valid && !stall;

    // Decode to execute register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out <= '0;
        end else begin
            out.valid <= issue;
            if (issue) begin
                out.pc <= pc;
                out.control <= control;
                out.imm <= imm;
                out.rs1_data <= rs1_data;
                out.rs2_data <= rs2_data;
                out.rs1 <= instr.r.rs1;
                out.rs2 <= instr.r.rs2;
                out.rd <= instr.r.rd;
            end
        end
    end

endmodule

// File: logic/rv32_scoreboard.sv
`timescale 1ns/1ns

module rv32_scoreboard (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 use_rs [rv32_types::CORE_RF_NUM_READ],
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic                 instr_valid,
    input  logic                 mark,
    input  logic [4:0]           mark_rd,
    input  rv32_types::wb_port_t wb,
    output logic                 stall
);

    // One bit per register still waiting for its write-back
    logic [31:0] pending;
    logic [31:0] clear_vec;
    logic [31:0] pending_now;

    always_comb begin
        clear_vec = 32'd0;
        if (wb.valid) begin
            clear_vec[wb.rd] = 1'b1;
        end
    end

    // A write-back arriving this cycle already resolves the hazard
    assign pending_now = pending & ~clear_vec;

    assign stall = instr_valid &&
                   ((use_rs[0] && pending_now[rs1]) || (use_rs[1] && pending_now[rs2]));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 32'd0;
        end else begin
            // Clear first so a fresh issue to the same rd stays pending
            pending <= pending_now;
            if (mark && (mark_rd != 5'd0)) begin
                pending[mark_rd] <= 1'b1;
            end
        end
    end

endmodule

// File: logic/rv32_reg_file.sv
`timescale 1ns/1ns

module rv32_reg_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  rv32_types::wb_port_t wb,
    output logic [31:0]          rs1_data,
    output logic [31:0]          rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    // One read port, with bypass of a same-cycle write-back
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (wb.valid && (wb.rd == addr)) begin
            return wb.data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wb.valid && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// File: logic/rv32_imm_gen.sv
`timescale 1ns/1ns

module rv32_imm_gen (
    input  rv32_types::rv_instr_t   instr,
    input  rv32_types::instr_type_t t,
    output logic [31:0]             imm
);

    always_comb begin
        case (t)
            rv32_types::INSTR_I_TYPE: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            rv32_types::INSTR_S_TYPE: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            // Branch offsets are halfword aligned
            rv32_types::INSTR_B_TYPE: begin
                imm = {{19{instr.b.imm_12}},
                       instr.b.imm_12,
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};
            end
            rv32_types::INSTR_U_TYPE: begin
                imm = {instr.u.imm_31_12, 12'b0};
            end
            rv32_types::INSTR_J_TYPE: begin
                imm = {{11{instr.j.imm_20}},
                       instr.j.imm_20,
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            // R type has no immediate
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

// File: logic/rv32_decoder.sv
`timescale 1ns/1ns

module rv32_decoder #(
    parameter bit ENABLE_GRNG = 1'b1
) (
    input  rv32_types::rv_instr_t   instr,
    output rv32_types::rv_control_t control,
    // Source register use, for hazard detection
    output logic                    use_rs [rv32_types::CORE_RF_NUM_READ]
);

    always_comb begin
        logic is_srai;

        is_srai = 1'b0;
        control = rv32_types::create_nop_ctrl();
        for (int idx = 0; idx < rv32_types::CORE_RF_NUM_READ; idx++) begin
            use_rs[idx] = 1'b0;
        end

        case (instr.r.opcode)
            // rd = 0 + U imm
            rv32_types::OPCODE_LUI: begin
                control.t = rv32_types::INSTR_U_TYPE;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_IMM;
                control.register_wb = 1'b1;
            end

            // rd = PC + U imm
            rv32_types::OPCODE_AUIPC: begin
                control.t = rv32_types::INSTR_U_TYPE;
                control.int_alu_instr.xbar[0] = rv32_types::ALU_IN_PC;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_IMM;
                control.register_wb = 1'b1;
            end

            // Target from ALU, link value PC + 4
            rv32_types::OPCODE_JAL: begin
                control.t = rv32_types::INSTR_J_TYPE;
                control.branch_op = rv32_types::OP_J;
                control.int_alu_instr.xbar[0] = rv32_types::ALU_IN_PC;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_IMM;
                control.wb_result_src = rv32_types::WB_PC4;
                control.register_wb = 1'b1;
            end

            rv32_types::OPCODE_JALR: begin
                control.t = rv32_types::INSTR_I_TYPE;
                control.branch_op = rv32_types::OP_J;
                control.int_alu_instr.xbar[0] = rv32_types::ALU_IN_REG_1;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_IMM;
                control.wb_result_src = rv32_types::WB_PC4;
                control.register_wb = 1'b1;
                use_rs[0] = 1'b1;
            end

            // ALU forms the target, the branch unit compares rs1 and rs2
            rv32_types::OPCODE_BRANCH: begin
                control.t = rv32_types::INSTR_B_TYPE;
                control.branch_op = rv32_types::branch_op_t'({1'b0, instr.b.funct3});
                control.int_alu_instr.xbar[0] = rv32_types::ALU_IN_PC;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_IMM;
                use_rs[0] = 1'b1;
                use_rs[1] = 1'b1;
            end

            rv32_types::OPCODE_INTEGER_IMM: begin
                // Only SRAI carries funct7[5] into the ALU op
                is_srai = (instr.r.funct3 == 3'b101) && instr.r.funct7[5];
                control.t = rv32_types::INSTR_I_TYPE;
                control.int_alu_instr.op =
                    rv32_types::int_alu_op_t'({is_srai, instr.r.funct3});
                control.register_wb = 1'b1;
                use_rs[0] = 1'b1;
            end

            rv32_types::OPCODE_INTEGER_REG: begin
                control.t = rv32_types::INSTR_R_TYPE;
                control.int_alu_instr.xbar[0] = rv32_types::ALU_IN_REG_1;
                control.int_alu_instr.xbar[1] = rv32_types::ALU_IN_REG_2;
                control.register_wb = 1'b1;
                use_rs[0] = 1'b1;
                use_rs[1] = 1'b1;
                if (instr.r.funct7 == rv32_types::FUNCT7_MUL) begin
                    control.wb_result_src = rv32_types::WB_MUL_UNIT;
                end else begin
                    control.int_alu_instr.op =
                        rv32_types::int_alu_op_t'({instr.r.funct7[5], instr.r.funct3});
                end
            end

            // Address rs1 + S imm, data from rs2
            rv32_types::OPCODE_STORE: begin
                control.t = rv32_types::INSTR_S_TYPE;
                control.mem_op.store = 1'b1;
                control.mem_op.funct3 = instr.s.funct3;
                control.wb_result_src = rv32_types::WB_STORE;
                use_rs[0] = 1'b1;
                use_rs[1] = 1'b1;
            end

            rv32_types::OPCODE_LOAD: begin
                control.t = rv32_types::INSTR_I_TYPE;
                control.mem_op.store = 1'b0;
                control.mem_op.funct3 = instr.i.funct3;
                control.wb_result_src = rv32_types::WB_MEM_DATA;
                control.register_wb = 1'b1;
                use_rs[0] = 1'b1;
            end

            rv32_types::OPCODE_ZICSR: begin
                control.wb_result_src = rv32_types::WB_CSR;
                control.register_wb = 1'b1;
                control.csr_wb = 1'b1;
                // Immediate forms carry a uimm in the rs1 field
                use_rs[0] = !instr.i.funct3[2];
            end

            rv32_types::OPCODE_GRNG: begin
                control.t = rv32_types::INSTR_R_TYPE;
                if (!ENABLE_GRNG) begin
                    control.invalid = 1'b1;
                end else if (instr.r.funct3 == rv32_types::GRNG_F3_SET_SEED) begin
                    control.grng_ctrl.set_seed = 1'b1;
                    use_rs[0] = 1'b1;
                end else if (instr.r.funct3 == rv32_types::GRNG_F3_RANDOM) begin
                    control.grng_ctrl.enable = 1'b1;
                    control.wb_result_src = rv32_types::WB_GRNG;
                    control.register_wb = 1'b1;
                end else begin
                    control.invalid = 1'b1;
                end
            end

            default: begin
                control.invalid = 1'b1;
            end
        endcase

        // Writes to x0 are dropped here
        if (instr.r.rd == 5'd0) begin
            control.register_wb = 1'b0;
        end
    end

endmodule

// File: logic/rv32_types.sv
package rv32_types;

    // Register read ports tracked by the decoder (rs1, rs2)
    localparam int CORE_RF_NUM_READ = 2;

    // Funct codes with a fixed meaning in decode
    localparam logic [6:0] FUNCT7_MUL = 7'b0000001;
    localparam logic [2:0] GRNG_F3_SET_SEED = 3'b000;
    localparam logic [2:0] GRNG_F3_RANDOM = 3'b001;

    typedef enum logic [6:0] {
        OPCODE_LUI         = 7'b0110111,
        OPCODE_AUIPC       = 7'b0010111,
        OPCODE_JAL         = 7'b1101111,
        OPCODE_JALR        = 7'b1100111,
        OPCODE_BRANCH      = 7'b1100011,
        OPCODE_INTEGER_IMM = 7'b0010011,
        OPCODE_INTEGER_REG = 7'b0110011,
        OPCODE_STORE       = 7'b0100011,
        OPCODE_LOAD        = 7'b0000011,
        OPCODE_ZICSR       = 7'b1110011,
        // custom-0 slot
        OPCODE_GRNG        = 7'b0001011
    } opcode_t;

    typedef enum logic [2:0] {
        INSTR_R_TYPE,
        INSTR_I_TYPE,
        INSTR_S_TYPE,
        INSTR_B_TYPE,
        INSTR_U_TYPE,
        INSTR_J_TYPE
    } instr_type_t;

    // Format views of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_instr_t;

    // {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } int_alu_op_t;

    typedef enum logic [1:0] {
        ALU_IN_REG_1,
        ALU_IN_REG_2,
        ALU_IN_PC,
        ALU_IN_IMM
    } alu_in_t;

    typedef struct packed {
        int_alu_op_t   op;
        alu_in_t [1:0] xbar;
    } int_alu_instr_t;

    // Low codes follow branch funct3
    typedef enum logic [3:0] {
        OP_BEQ  = 4'b0000,
        OP_BNE  = 4'b0001,
        OP_BLT  = 4'b0100,
        OP_BGE  = 4'b0101,
        OP_BLTU = 4'b0110,
        OP_BGEU = 4'b0111,
        OP_J    = 4'b1000,
        OP_NONE = 4'b1111
    } branch_op_t;

    typedef struct packed {
        logic       store;
        logic [2:0] funct3;
    } mem_op_t;

    // funct3 of 111 is unused by loads and stores
    localparam mem_op_t MEM_OP_NONE = '{store: 1'b1, funct3: 3'b111};

    typedef enum logic [2:0] {
        WB_ALU,
        WB_PC4,
        WB_MEM_DATA,
        WB_MUL_UNIT,
        WB_CSR,
        WB_GRNG,
        WB_STORE
    } wb_src_t;

    typedef struct packed {
        logic set_seed;
        logic enable;
    } grng_ctrl_t;

    typedef struct packed {
        instr_type_t    t;
        int_alu_instr_t int_alu_instr;
        branch_op_t     branch_op;
        mem_op_t        mem_op;
        wb_src_t        wb_result_src;
        logic           register_wb;
        logic           csr_wb;
        grng_ctrl_t     grng_ctrl;
        logic           invalid;
    } rv_control_t;

    // Control bundle of add x0, x0, 0
    function automatic rv_control_t create_nop_ctrl();
        rv_control_t ctrl;
        ctrl.t = INSTR_I_TYPE;
        ctrl.int_alu_instr.op = ALU_ADD;
        ctrl.int_alu_instr.xbar[0] = ALU_IN_REG_1;
        ctrl.int_alu_instr.xbar[1] = ALU_IN_IMM;
        ctrl.branch_op = OP_NONE;
        ctrl.mem_op = MEM_OP_NONE;
        ctrl.wb_result_src = WB_ALU;
        ctrl.register_wb = 1'b0;
        ctrl.csr_wb = 1'b0;
        ctrl.grng_ctrl = '0;
        ctrl.invalid = 1'b0;
        return ctrl;
    endfunction

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_port_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        rv_control_t control;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } decode_out_t;

endpackage
